// ==== hw/cpu4Pkg.sv ====
`default_nettype none

package cpu4Pkg;

    // ------------------------------
    // Instruction fields
    // ------------------------------
    localparam int regCount = 16;            // Index registers R0..R15

    typedef logic [$clog2(regCount)-1:0] regIdxT;

    // High nibble of the instruction word
    typedef enum logic [3:0] {
        NOP    = 4'h0,
        JCN    = 4'h1,
        INC    = 4'h6,
        ADD    = 4'h8,
        SUB    = 4'h9,
        LD     = 4'hA,
        XCH    = 4'hB,
        LDM    = 4'hD,
        ACCGRP = 4'hF
    } oprE;

    // Low nibble when the opcode is ACCGRP
    typedef enum logic [3:0] {
        CLB = 4'h0,
        CLC = 4'h1,
        IAC = 4'h2,
        CMC = 4'h3,
        CMA = 4'h4,
        RAL = 4'h5,
        RAR = 4'h6,
        TCC = 4'h7,
        DAC = 4'h8,
        STC = 4'hA
    } accSubE;

    // ------------------------------
    // Internal control
    // ------------------------------
    typedef enum logic [3:0] {
        aluNop, aluLdm, aluLd,  aluXch, aluInc,
        aluAdd, aluSub, aluClb, aluIac, aluCma,
        aluRal, aluRar, aluTcc, aluDac, aluJcn
    } aluOpE;

    typedef enum logic [2:0] {
        cmKeep,
        cmFromAlu,     // Carry-out of the ALU result
        cmClear,
        cmSet,
        cmInvert
    } carryModeE;

endpackage

`default_nettype wire

// ==== hw/reqAckPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module reqAckPort (
    input  wire  clk,
    input  wire  rstN,
    input  logic req,
    input  logic done,
    output logic start,
    output logic ack
);

    typedef enum logic [1:0] {stIdle, stBusy, stAcked} stateE;

    stateE state;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= stIdle;
            start <= 1'b0;
            ack   <= 1'b0;
        end else begin
            start <= 1'b0;                       // Single-cycle pulse
            unique case (state)
                stIdle: if (req) begin
                    state <= stBusy;
                    start <= 1'b1;
                end
                stBusy: if (done) begin
                    state <= stAcked;
                    ack   <= 1'b1;
                end
                stAcked: if (!req) begin         // Host closes the handshake
                    state <= stIdle;
                    ack   <= 1'b0;
                end
                default: state <= stIdle;
            endcase
        end
    end

    // Ack only answers a request the host is still holding
    ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> $past(req));

    // Commit stage reports back only for an accepted instruction
    doneWhileBusy: assert property (@(posedge clk) disable iff (!rstN)
        done |-> state == stBusy);

endmodule

`default_nettype wire

// ==== hw/instrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
    input  wire                       clk,
    input  wire                       rstN,
    input  logic                      start,
    input  logic [7:0]                instr,
    output logic                      ctlValid,
    output cpu4Pkg::aluOpE            aluOp,
    output cpu4Pkg::carryModeE        carryMode,
    output cpu4Pkg::regIdxT           regIdx,
    output logic [3:0]                operand,
    output logic                      accWe,
    output logic                      regWe
);

    cpu4Pkg::oprE       oprCode;
    cpu4Pkg::accSubE    subCode;
    cpu4Pkg::aluOpE     aluOpNext;
    cpu4Pkg::carryModeE carryModeNext;
    logic               accWeNext;
    logic               regWeNext;

    assign oprCode = cpu4Pkg::oprE'(instr[7:4]);
    assign subCode = cpu4Pkg::accSubE'(instr[3:0]);

    // ------------------------------
    // Opcode to control fields
    // ------------------------------
    always_comb begin
        aluOpNext     = cpu4Pkg::aluNop;   // Unknown codes fall through as NOP
        carryModeNext = cpu4Pkg::cmKeep;
        accWeNext     = 1'b0;
        regWeNext     = 1'b0;
        case (oprCode)
            cpu4Pkg::JCN: aluOpNext = cpu4Pkg::aluJcn;   // Only condMet changes
            cpu4Pkg::INC: begin
                aluOpNext = cpu4Pkg::aluInc;
                regWeNext = 1'b1;
            end
            cpu4Pkg::ADD, cpu4Pkg::SUB: begin
                aluOpNext     = (oprCode == cpu4Pkg::ADD) ? cpu4Pkg::aluAdd : cpu4Pkg::aluSub;
                carryModeNext = cpu4Pkg::cmFromAlu;
                accWeNext     = 1'b1;
            end
            cpu4Pkg::LD:  {aluOpNext, accWeNext} = {cpu4Pkg::aluLd, 1'b1};
            cpu4Pkg::LDM: {aluOpNext, accWeNext} = {cpu4Pkg::aluLdm, 1'b1};
            cpu4Pkg::XCH: begin
                aluOpNext = cpu4Pkg::aluXch;
                accWeNext = 1'b1;
                regWeNext = 1'b1;
            end
            cpu4Pkg::ACCGRP: begin
                case (subCode)
                    cpu4Pkg::CLB: {aluOpNext, carryModeNext} = {cpu4Pkg::aluClb, cpu4Pkg::cmClear};
                    cpu4Pkg::CLC: carryModeNext = cpu4Pkg::cmClear;
                    cpu4Pkg::IAC: {aluOpNext, carryModeNext} = {cpu4Pkg::aluIac, cpu4Pkg::cmFromAlu};
                    cpu4Pkg::CMC: carryModeNext = cpu4Pkg::cmInvert;
                    cpu4Pkg::CMA: aluOpNext = cpu4Pkg::aluCma;
                    cpu4Pkg::RAL: {aluOpNext, carryModeNext} = {cpu4Pkg::aluRal, cpu4Pkg::cmFromAlu};
                    cpu4Pkg::RAR: {aluOpNext, carryModeNext} = {cpu4Pkg::aluRar, cpu4Pkg::cmFromAlu};
                    cpu4Pkg::TCC: {aluOpNext, carryModeNext} = {cpu4Pkg::aluTcc, cpu4Pkg::cmClear};
                    cpu4Pkg::DAC: {aluOpNext, carryModeNext} = {cpu4Pkg::aluDac, cpu4Pkg::cmFromAlu};
                    cpu4Pkg::STC: carryModeNext = cpu4Pkg::cmSet;
                    default: ;
                endcase
                // Every ACC-group op with an ALU result writes the accumulator
                accWeNext = (aluOpNext != cpu4Pkg::aluNop);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctlValid  <= 1'b0;
            accWe     <= 1'b0;
            regWe     <= 1'b0;
            aluOp     <= cpu4Pkg::aluNop;
            carryMode <= cpu4Pkg::cmKeep;
        end else begin
            ctlValid <= start;
            accWe    <= start & accWeNext;
            regWe    <= start & regWeNext;
            if (start) begin
                aluOp     <= aluOpNext;
                carryMode <= carryModeNext;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            regIdx  <= cpu4Pkg::regIdxT'(instr[3:0]);
            operand <= instr[3:0];                 // Immediate or JCN condition
        end
    end

    // Only XCH writes both the accumulator and a register
    dualWriteIsXch: assert property (@(posedge clk) disable iff (!rstN)
        (accWe && regWe) |-> aluOp == cpu4Pkg::aluXch);

endmodule

`default_nettype wire

// ==== hw/regBank.sv ====
`timescale 1ns/1ps
`default_nettype none

module regBank #(
    parameter int dataWidth = 4
) (
    input  wire                    clk,
    input  wire                    rstN,
    input  cpu4Pkg::regIdxT        rdIdx,
    output logic [dataWidth-1:0]   rdData,
    input  logic                   wrEn,
    input  cpu4Pkg::regIdxT        wrIdx,
    input  logic [dataWidth-1:0]   wrData
);

    logic [dataWidth-1:0] regs [cpu4Pkg::regCount];

    // ------------------------------
    // Read is combinational
    // ------------------------------
    assign rdData = regs[rdIdx];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < cpu4Pkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrIdx] <= wrData;
        end
    end

endmodule

`default_nettype wire

// ==== hw/aluExecute.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluExecute #(
    parameter int dataWidth = 4
) (
    input  wire                     clk,
    input  wire                     rstN,
    input  logic                    ctlValid,
    input  cpu4Pkg::aluOpE          aluOp,
    input  cpu4Pkg::carryModeE      carryMode,
    input  cpu4Pkg::regIdxT         regIdx,
    input  logic [3:0]              operand,
    input  logic                    accWe,
    input  logic                    regWe,
    input  logic [dataWidth-1:0]    acc,
    input  logic                    carry,
    input  logic                    testPin,
    input  logic [dataWidth-1:0]    rdData,
    output cpu4Pkg::regIdxT         rdIdx,
    output logic                    exValid,
    output logic [dataWidth-1:0]    newAcc,
    output logic [dataWidth-1:0]    newReg,
    output logic                    newCarry,
    output logic                    newCondMet,
    output logic                    accWeOut,
    output logic                    regWeOut,
    output cpu4Pkg::regIdxT         wrIdx
);

    logic [dataWidth-1:0] accRes;
    logic [dataWidth-1:0] regRes;
    logic                 aluCout;
    logic                 carryRes;
    logic                 condRes;

    assign rdIdx = regIdx;

    // ------------------------------
    // Result datapath
    // ------------------------------
    always_comb begin
        accRes  = acc;
        regRes  = rdData;
        aluCout = 1'b0;
        case (aluOp)
            cpu4Pkg::aluLdm: accRes = dataWidth'(operand);     // Zero-extended immediate
            cpu4Pkg::aluLd:  accRes = rdData;
            cpu4Pkg::aluXch: begin
                accRes = rdData;
                regRes = acc;
            end
            cpu4Pkg::aluInc: regRes = rdData + 1'b1;           // Carry untouched
            cpu4Pkg::aluAdd:
                {aluCout, accRes} = {1'b0, acc} + {1'b0, rdData} + (dataWidth+1)'(carry);
            cpu4Pkg::aluSub:
                {aluCout, accRes} = {1'b0, acc} + {1'b0, ~rdData} + {{dataWidth{1'b0}}, ~carry};
            cpu4Pkg::aluClb: accRes = '0;
            cpu4Pkg::aluIac: {aluCout, accRes} = {1'b0, acc} + 1'b1;
            cpu4Pkg::aluCma: accRes = ~acc;
            cpu4Pkg::aluRal: {aluCout, accRes} = {acc, carry};   // Carry into bit 0
            cpu4Pkg::aluRar: {accRes, aluCout} = {carry, acc};   // Carry into MSB
            cpu4Pkg::aluTcc: accRes = dataWidth'(carry);
            cpu4Pkg::aluDac: {aluCout, accRes} = {1'b0, acc} + {1'b0, {dataWidth{1'b1}}};
            default: ;
        endcase
    end

    // Carry update per decoded mode
    always_comb begin
        case (carryMode)
            cpu4Pkg::cmFromAlu: carryRes = aluCout;
            cpu4Pkg::cmClear:   carryRes = 1'b0;
            cpu4Pkg::cmSet:     carryRes = 1'b1;
            cpu4Pkg::cmInvert:  carryRes = ~carry;
            default:            carryRes = carry;
        endcase
    end

    // JCN test, low for every other instruction
    assign condRes = (aluOp == cpu4Pkg::aluJcn) &
                     (operand[3] ^ ((~testPin & operand[0]) |
                                    (carry & operand[1]) |
                                    ((acc == '0) & operand[2])));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exValid  <= 1'b0;
            accWeOut <= 1'b0;
            regWeOut <= 1'b0;
        end else begin
            exValid  <= ctlValid;
            accWeOut <= ctlValid & accWe;
            regWeOut <= ctlValid & regWe;
        end
    end

    always_ff @(posedge clk) begin
        if (ctlValid) begin
            newAcc     <= accRes;
            newReg     <= regRes;
            newCarry   <= carryRes;
            newCondMet <= condRes;
            wrIdx      <= regIdx;
        end
    end

endmodule

`default_nettype wire

// ==== hw/resultCommit.sv ====
`timescale 1ns/1ps
`default_nettype none

module resultCommit #(
    parameter int dataWidth = 4
) (
    input  wire                    clk,
    input  wire                    rstN,
    input  logic                   exValid,
    input  logic [dataWidth-1:0]   newAcc,
    input  logic [dataWidth-1:0]   newReg,
    input  logic                   newCarry,
    input  logic                   newCondMet,
    input  logic                   accWe,
    input  logic                   regWe,
    input  cpu4Pkg::regIdxT        wrIdx,
    output logic [dataWidth-1:0]   acc,
    output logic                   carry,
    output logic                   condMet,
    output logic                   done,
    output logic                   regWrEn,
    output cpu4Pkg::regIdxT        regWrIdx,
    output logic [dataWidth-1:0]   regWrData
);

    // ------------------------------
    // Architectural state
    // ------------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            acc     <= '0;
            carry   <= 1'b0;
            condMet <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= exValid;
            if (exValid) begin
                if (accWe) acc <= newAcc;
                carry   <= newCarry;          // Equals old carry when kept
                condMet <= newCondMet;        // Low unless last op was JCN
            end
        end
    end

    // Register write lands on the same edge as acc
    assign regWrEn   = exValid & regWe;
    assign regWrIdx  = wrIdx;
    assign regWrData = newReg;

    // One instruction in flight, so commits never come back to back
    doneSingle: assert property (@(posedge clk) disable iff (!rstN)
        done |=> !done);

endmodule

`default_nettype wire

// ==== hw/cpuCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCore #(
    parameter int dataWidth = 4
) (
    input  wire                    clk,
    input  wire                    rstN,
    input  logic [7:0]             instr,
    input  logic                   req,
    input  logic                   testPin,
    output logic                   ack,
    output logic [dataWidth-1:0]   acc,
    output logic                   carry,
    output logic                   condMet
);

    logic start, done;
    // Decode stage
    logic ctlValid, dAccWe, dRegWe;
    logic [3:0] operand;
    cpu4Pkg::aluOpE aluOp;
    cpu4Pkg::carryModeE carryMode;
    cpu4Pkg::regIdxT regIdx, rdIdx;
    // Execute stage
    logic exValid, newCarry, newCondMet, xAccWe, xRegWe;
    logic [dataWidth-1:0] newAcc, newReg, rdData;
    cpu4Pkg::regIdxT xWrIdx;
    // Register write port
    logic regWrEn;
    cpu4Pkg::regIdxT regWrIdx;
    logic [dataWidth-1:0] regWrData;

    reqAckPort reqAckPort_inst (
        .clk(clk), .rstN(rstN), .req(req), .done(done), .start(start), .ack(ack)
    );

    instrDecode instrDecode_inst (
        .clk(clk), .rstN(rstN), .start(start), .instr(instr),
        .ctlValid(ctlValid), .aluOp(aluOp), .carryMode(carryMode), .regIdx(regIdx),
        .operand(operand), .accWe(dAccWe), .regWe(dRegWe)
    );

    regBank #(.dataWidth(dataWidth)) regBank_inst (
        .clk(clk), .rstN(rstN), .rdIdx(rdIdx), .rdData(rdData),
        .wrEn(regWrEn), .wrIdx(regWrIdx), .wrData(regWrData)
    );

    aluExecute #(.dataWidth(dataWidth)) aluExecute_inst (
        .clk(clk), .rstN(rstN), .ctlValid(ctlValid), .aluOp(aluOp), .carryMode(carryMode),
        .regIdx(regIdx), .operand(operand), .accWe(dAccWe), .regWe(dRegWe), .acc(acc),
        .carry(carry), .testPin(testPin), .rdData(rdData), .rdIdx(rdIdx),
        .exValid(exValid), .newAcc(newAcc), .newReg(newReg), .newCarry(newCarry),
        .newCondMet(newCondMet), .accWeOut(xAccWe), .regWeOut(xRegWe), .wrIdx(xWrIdx)
    );

    resultCommit #(.dataWidth(dataWidth)) resultCommit_inst (
        .clk(clk), .rstN(rstN), .exValid(exValid), .newAcc(newAcc), .newReg(newReg),
        .newCarry(newCarry), .newCondMet(newCondMet), .accWe(xAccWe), .regWe(xRegWe),
        .wrIdx(xWrIdx), .acc(acc), .carry(carry), .condMet(condMet), .done(done),
        .regWrEn(regWrEn), .regWrIdx(regWrIdx), .regWrData(regWrData)
    );

endmodule

`default_nettype wire

// ==== bench/refModel.svh ====
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// Architectural state after reset
function automatic void clearModel();
    expAcc   = 4'h0;
    expCarry = 1'b0;
    expCond  = 1'b0;
    for (int i = 0; i < 16; i++) begin
        expRegs[i] = 4'h0;
    end
endfunction

// Advance the model by one instruction
function automatic void applyModel(input logic [7:0] ins, input logic tp);
    logic [3:0] opc;
    logic [3:0] arg;
    logic [4:0] sum;
    logic [3:0] tmp;
    logic       anyTerm;
    opc     = ins[7:4];
    arg     = ins[3:0];
    sum     = 5'h00;
    tmp     = 4'h0;
    anyTerm = 1'b0;
    expCond = 1'b0;                                  // Only JCN leaves it set
    case (opc)
        cpu4Pkg::JCN: begin
            anyTerm = (!tp && arg[0]) || (expCarry && arg[1]) || (expAcc == 4'h0 && arg[2]);
            expCond = arg[3] ? !anyTerm : anyTerm;
        end
        cpu4Pkg::INC: expRegs[arg] = expRegs[arg] + 4'h1;
        cpu4Pkg::ADD: begin
            sum      = {1'b0, expAcc} + {1'b0, expRegs[arg]} + {4'h0, expCarry};
            expAcc   = sum[3:0];
            expCarry = sum[4];
        end
        cpu4Pkg::SUB: begin
            sum      = {1'b0, expAcc} + {1'b0, ~expRegs[arg]} + {4'h0, ~expCarry};
            expAcc   = sum[3:0];
            expCarry = sum[4];
        end
        cpu4Pkg::LD:  expAcc = expRegs[arg];
        cpu4Pkg::LDM: expAcc = arg;
        cpu4Pkg::XCH: begin
            tmp          = expRegs[arg];
            expRegs[arg] = expAcc;
            expAcc       = tmp;
        end
        cpu4Pkg::ACCGRP: begin
            case (arg)
                cpu4Pkg::CLB: begin
                    expAcc   = 4'h0;
                    expCarry = 1'b0;
                end
                cpu4Pkg::CLC: expCarry = 1'b0;
                cpu4Pkg::IAC: begin
                    expCarry = (expAcc == 4'hF);     // Wraps to zero
                    expAcc   = expAcc + 4'h1;
                end
                cpu4Pkg::CMC: expCarry = !expCarry;
                cpu4Pkg::CMA: expAcc = ~expAcc;
                cpu4Pkg::RAL: begin
                    anyTerm  = expAcc[3];
                    expAcc   = {expAcc[2:0], expCarry};
                    expCarry = anyTerm;
                end
                cpu4Pkg::RAR: begin
                    anyTerm  = expAcc[0];
                    expAcc   = {expCarry, expAcc[3:1]};
                    expCarry = anyTerm;
                end
                cpu4Pkg::TCC: begin
                    expAcc   = {3'b000, expCarry};
                    expCarry = 1'b0;
                end
                cpu4Pkg::DAC: begin
                    expCarry = (expAcc != 4'h0);     // Set when no borrow
                    expAcc   = expAcc - 4'h1;
                end
                cpu4Pkg::STC: expCarry = 1'b1;
                default: ;
            endcase
        end
        default: ;
    endcase
endfunction

`endif

// ==== bench/tbCpuCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbCpuCore;

    localparam int dataWidth  = 4;
    localparam int ackTimeout = 20;                  // Cycles, ack normally needs 5
    localparam int randCount  = 120;

    logic                 clk = 1'b0;
    logic                 rstN;
    logic [7:0]           instr;
    logic                 req;
    logic                 testPin;
    logic                 ack;
    logic [dataWidth-1:0] acc;
    logic                 carry;
    logic                 condMet;

    // Reference state
    logic [3:0] expAcc;
    logic       expCarry;
    logic       expCond;
    logic [3:0] expRegs [16];

    string      curTest;
    logic [7:0] curInstr;
    int         errCount;
    int         testErrStart;
    int         testsRun;
    int         testsFailed;
    logic       timedOut;

    `include "refModel.svh"

    always #5 clk = ~clk;

    cpuCore #(.dataWidth(dataWidth)) cpuCore_inst (
        .clk(clk), .rstN(rstN), .instr(instr), .req(req), .testPin(testPin),
        .ack(ack), .acc(acc), .carry(carry), .condMet(condMet)
    );

    function automatic void reportMismatch(input string what, input logic [3:0] expVal,
                                           input logic [3:0] actVal);
        errCount++;
        $display("mismatch in test %s: %s after instr %h, expected %h, actual %h",
                 curTest, what, curInstr, expVal, actVal);
    endfunction

    function automatic void reportFailure(input string what);
        errCount++;
        $display("error in test %s: %s (instr %h)", curTest, what, curInstr);
    endfunction

    // ------------------------------
    // Checks
    // ------------------------------
    resetState: assert property (@(posedge clk)
        $rose(rstN) |-> !ack && acc == '0 && !carry && !condMet)
        else reportFailure("state after reset is not cleared");

    accAtAck: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> acc == expAcc)
        else reportMismatch("acc", expAcc, acc);

    carryAtAck: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> carry == expCarry)
        else reportMismatch("carry", {3'b000, expCarry}, {3'b000, carry});

    condAtAck: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> condMet == expCond)
        else reportMismatch("condMet", {3'b000, expCond}, {3'b000, condMet});

    // Edge E4 updates ack, seen at the following edge
    ackLatency: assert property (@(posedge clk) disable iff (!rstN)
        $rose(req) |-> ##5 $rose(ack))
        else reportFailure("ack did not rise four cycles after req was sampled");

    ackHeld: assert property (@(posedge clk) disable iff (!rstN)
        ack && req |=> ack)
        else reportFailure("ack dropped while req was still high");

    ackRelease: assert property (@(posedge clk) disable iff (!rstN)
        $fell(req) |-> ack ##1 !ack)
        else reportFailure("ack did not fall one cycle after req fell");

    ackIdle: assert property (@(posedge clk) disable iff (!rstN)
        !req && !ack |=> !ack)
        else reportFailure("ack rose while the core was idle");

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    function automatic logic [7:0] mkInstr(input logic [3:0] opc, input logic [3:0] arg);
        return {opc, arg};
    endfunction

    // One full four-phase transfer, req held for hold extra cycles
    task automatic runInstr(input logic [7:0] ins, input logic tp, input int hold);
        int waitCnt;
        if (!timedOut) begin
            @(negedge clk);
            applyModel(ins, tp);
            curInstr = ins;
            instr    = ins;
            testPin  = tp;
            req      = 1'b1;
            waitCnt  = 0;
            while (ack !== 1'b1 && waitCnt < ackTimeout) begin
                @(negedge clk);
                waitCnt++;
            end
            if (ack !== 1'b1) begin
                timedOut = 1'b1;
                $display("timeout in test %s: no ack for instr %h", curTest, ins);
            end else begin
                repeat (hold) @(negedge clk);
                req     = 1'b0;
                waitCnt = 0;
                while (ack !== 1'b0 && waitCnt < ackTimeout) begin
                    @(negedge clk);
                    waitCnt++;
                end
                if (ack !== 1'b0) begin
                    timedOut = 1'b1;
                    $display("timeout in test %s: ack stuck high for instr %h", curTest, ins);
                end
            end
        end
    endtask

    task automatic beginTest(input string name);
        curTest      = name;
        testErrStart = errCount;
    endtask

    task automatic endTest();
        testsRun++;
        if (errCount == testErrStart && !timedOut) begin
            $display("test %s: ok", curTest);
        end else begin
            testsFailed++;
            $display("test %s: %0d error(s)%s", curTest, errCount - testErrStart,
                     timedOut ? ", stopped by timeout" : "");
        end
    endtask

    initial begin
        void'($urandom(32'h53bff71b));
        rstN     = 1'b0;
        req      = 1'b0;
        instr    = 8'h00;
        testPin  = 1'b0;
        curInstr = 8'h00;
        errCount = 0;
        testsRun = 0;
        testsFailed = 0;
        timedOut = 1'b0;
        clearModel();

        beginTest("reset");
        repeat (5) @(negedge clk);
        rstN = 1'b1;
        repeat (2) @(negedge clk);
        endTest();

        beginTest("dataMove");
        runInstr(mkInstr(cpu4Pkg::ACCGRP, cpu4Pkg::STC), 1'b0, 0);   // Carry must survive
        runInstr(mkInstr(cpu4Pkg::LDM, 4'h5), 1'b0, 0);
        runInstr(mkInstr(cpu4Pkg::XCH, 4'h3), 1'b0, 0);
        runInstr(mkInstr(cpu4Pkg::LDM, 4'hA), 1'b0, 0);
        runInstr(mkInstr(cpu4Pkg::XCH, 4'h7), 1'b0, 0);
        runInstr(mkInstr(cpu4Pkg::LD, 4'h3), 1'b0, 0);
        runInstr(mkInstr(cpu4Pkg::INC, 4'h3), 1'b0, 0);
        runInstr(mkInstr(cpu4Pkg::INC, 4'hF), 1'b0, 0);
        runInstr(mkInstr(cpu4Pkg::LD, 4'h3), 1'b0, 0);
        runInstr(mkInstr(cpu4Pkg::XCH, 4'h7), 1'b0, 0);
        runInstr(mkInstr(cpu4Pkg::LD, 4'h7), 1'b0, 0);
        runInstr(mkInstr(cpu4Pkg::LD, 4'hF), 1'b0, 0);
        endTest();

        beginTest("arith");
        for (int i = 0; i < 16; i++) begin
            runInstr(mkInstr(cpu4Pkg::LDM, 4'(i * 3)), 1'b0, 0);
            runInstr(mkInstr(cpu4Pkg::ADD, 4'(i)), 1'b0, 0);
            runInstr(mkInstr(cpu4Pkg::SUB, 4'(i + 5)), 1'b0, 0);
            runInstr(mkInstr(cpu4Pkg::XCH, 4'(i)), 1'b0, 0);   // Fresh register values
        end
        endTest();

        beginTest("accGroup");
        for (int c = 0; c < 2; c++) begin
            for (int s = 0; s < 16; s++) begin
                runInstr(mkInstr(cpu4Pkg::LDM, 4'(s * 5 + c)), 1'b0, 0);
                runInstr(mkInstr(cpu4Pkg::ACCGRP, c ? cpu4Pkg::STC : cpu4Pkg::CLC), 1'b0, 0);
                runInstr(mkInstr(cpu4Pkg::ACCGRP, 4'(s)), 1'b0, 0);
            end
        end
        endTest();

        beginTest("jcn");
        for (int z = 0; z < 2; z++) begin
            for (int c = 0; c < 2; c++) begin
                runInstr(mkInstr(cpu4Pkg::LDM, z ? 4'h0 : 4'h6), 1'b0, 0);
                runInstr(mkInstr(cpu4Pkg::ACCGRP, c ? cpu4Pkg::STC : cpu4Pkg::CLC), 1'b0, 0);
                for (int cond = 0; cond < 16; cond++) begin
                    runInstr(mkInstr(cpu4Pkg::JCN, 4'(cond)), 1'b0, 0);
                    runInstr(mkInstr(cpu4Pkg::JCN, 4'(cond)), 1'b1, 0);
                end
            end
        end
        endTest();

        beginTest("handshake");
        for (int h = 0; h < 6; h++) begin
            runInstr(mkInstr(cpu4Pkg::LDM, 4'(h + 9)), 1'b0, h);       // Stretched phase 3
            runInstr(mkInstr(4'(h + 2), 4'hC), 1'b0, h);               // Opcodes 2..7, 6 is INC
            runInstr(mkInstr(4'hC, 4'(h)), 1'b1, h);
            runInstr(mkInstr(4'hE, 4'(h)), 1'b0, h);
        end
        endTest();

        beginTest("random");
        for (int n = 0; n < randCount; n++) begin
            runInstr(8'($urandom), 1'($urandom), int'($urandom % 3));
        end
        endTest();

        $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
        if (errCount == 0 && !timedOut) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+bench
hw/cpu4Pkg.sv
hw/reqAckPort.sv
hw/instrDecode.sv
hw/regBank.sv
hw/aluExecute.sv
hw/resultCommit.sv
hw/cpuCore.sv
bench/tbCpuCore.sv

// ==== Bender.yml ====
package:
  name: cpu4core

sources:
  - hw/cpu4Pkg.sv
  - hw/reqAckPort.sv
  - hw/instrDecode.sv
  - hw/regBank.sv
  - hw/aluExecute.sv
  - hw/resultCommit.sv
  - hw/cpuCore.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tbCpuCore.sv
